/* hdl/toe_stream_pkg.sv */
package toe_stream_pkg;

  // payload stream between the offload engine and the application
  localparam int data_width_c = 64;
  localparam int keep_width_c = data_width_c / 8; // one keep bit per byte

  // receive buffer
  localparam int rx_buffer_depth_c = 1024;
  localparam int fill_count_width_c = 16; // engine flow control input width

  // metadata words on the application side
  localparam int listen_port_width_c = 16;
  localparam int notification_width_c = 88; // session, length, ip, port, flags

endpackage

/* hdl/toe_mem_pkg.sv */
package toe_mem_pkg;

  localparam int mem_cmd_word_width_c = 72;
  localparam int mem_addr_width_c = 64;
  localparam int mem_len_width_c = 32;

  // fields inside the command word as the engine emits it
  localparam int cmd_addr_field_width_c = 32;
  localparam int cmd_len_field_width_c = 23;

  localparam int stat_count_width_c = 16;

  // top bit first: bits 71:64 reserved, 63:32 address, 31:23 pad, 22:0 length
  typedef struct packed {
    logic [7:0] reserved;
    logic [cmd_addr_field_width_c-1:0] addr;
    logic [8:0] pad;
    logic [cmd_len_field_width_c-1:0] len;
  } mem_cmd_fields_t;

  typedef union packed {
    logic [mem_cmd_word_width_c-1:0] raw; // as seen on the engine port
    mem_cmd_fields_t fields;
  } mem_cmd_word_u;

endpackage

/* hdl/meta_reg_slice.sv */
module meta_reg_slice #(
  parameter int WIDTH = toe_stream_pkg::listen_port_width_c
) (
  input  logic             net_clk,
  input  logic             net_aresetn,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  logic             main_valid;
  logic [WIDTH-1:0] main_data;
  logic             skid_valid;
  logic [WIDTH-1:0] skid_data;
  logic             main_load; // main register free to take a new word

  assign main_load = out_ready || !main_valid;
  assign in_ready  = !skid_valid; // registered, no path from out_ready
  assign out_valid = main_valid;
  assign out_data  = main_data;

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      main_valid <= skid_valid || in_valid;
      skid_valid <= 1'b0; // skid drains first
    end else if (in_valid && in_ready) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge net_clk) begin
    if (main_load) begin
      main_data <= skid_valid ? skid_data : in_data;
    end else if (in_valid && in_ready) begin
      skid_data <= in_data;
    end
  end

  // a stalled word must not change under the consumer
  a_out_stable : assert property (@(posedge net_clk) disable iff (!net_aresetn)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

/* hdl/rx_buffer_fifo.sv */
module rx_buffer_fifo #(
  parameter int DATA_WIDTH      = toe_stream_pkg::data_width_c,
  parameter int KEEP_WIDTH      = toe_stream_pkg::keep_width_c,
  parameter int RX_BUFFER_DEPTH = toe_stream_pkg::rx_buffer_depth_c
) (
  input  logic                  net_clk,
  input  logic                  net_aresetn,
  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic [KEEP_WIDTH-1:0] in_keep,
  input  logic                  in_last,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic [KEEP_WIDTH-1:0] out_keep,
  output logic                  out_last,
  output logic [toe_stream_pkg::fill_count_width_c-1:0] fill_count
);

  localparam int PTR_W   = (RX_BUFFER_DEPTH > 1) ? $clog2(RX_BUFFER_DEPTH) : 1;
  localparam int OCC_W   = $clog2(RX_BUFFER_DEPTH + 1);
  localparam int FCW     = toe_stream_pkg::fill_count_width_c;
  localparam int ENTRY_W = DATA_WIDTH + KEEP_WIDTH + 1;

  logic [ENTRY_W-1:0] mem [RX_BUFFER_DEPTH]; // {last, keep, data}
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [OCC_W-1:0]   occ_cnt;
  logic               wr_en;
  logic               rd_en;
  logic [FCW-1:0]     fill_q1;
  logic [FCW-1:0]     fill_q2;

  assign in_ready  = (occ_cnt != OCC_W'(RX_BUFFER_DEPTH));
  assign out_valid = (occ_cnt != '0);
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  assign {out_last, out_keep, out_data} = mem[rd_ptr];

  always_ff @(posedge net_clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= {in_last, in_keep, in_data};
    end
  end

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      occ_cnt <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(RX_BUFFER_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(RX_BUFFER_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (wr_en && !rd_en) begin
        occ_cnt <= occ_cnt + 1'b1;
      end else if (rd_en && !wr_en) begin
        occ_cnt <= occ_cnt - 1'b1;
      end
    end
  end

  // two stages toward the engine, matches its flow control timing
  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      fill_q1 <= '0;
      fill_q2 <= '0;
    end else begin
      fill_q1 <= FCW'(occ_cnt); // clipped or zero extended
      fill_q2 <= fill_q1;
    end
  end

  assign fill_count = fill_q2;

  a_occ_bound : assert property (@(posedge net_clk) disable iff (!net_aresetn)
    occ_cnt <= OCC_W'(RX_BUFFER_DEPTH));

  a_no_write_full : assert property (@(posedge net_clk) disable iff (!net_aresetn)
    occ_cnt == OCC_W'(RX_BUFFER_DEPTH) && !rd_en |=> occ_cnt == OCC_W'(RX_BUFFER_DEPTH));

endmodule

/* hdl/tx_mem_port.sv */
module tx_mem_port #(
  parameter int DATA_WIDTH = toe_stream_pkg::data_width_c,
  parameter int KEEP_WIDTH = toe_stream_pkg::keep_width_c
) (
  input  logic                                      net_clk,
  input  logic                                      net_aresetn,
  input  logic                                      rd_cmd_valid,
  output logic                                      rd_cmd_ready,
  input  toe_mem_pkg::mem_cmd_word_u                rd_cmd_word,
  output logic                                      mem_rd_cmd_valid,
  input  logic                                      mem_rd_cmd_ready,
  output logic [toe_mem_pkg::mem_addr_width_c-1:0]  mem_rd_cmd_addr,
  output logic [toe_mem_pkg::mem_len_width_c-1:0]   mem_rd_cmd_len,
  input  logic                                      wr_cmd_valid,
  output logic                                      wr_cmd_ready,
  input  toe_mem_pkg::mem_cmd_word_u                wr_cmd_word,
  output logic                                      mem_wr_cmd_valid,
  input  logic                                      mem_wr_cmd_ready,
  output logic [toe_mem_pkg::mem_addr_width_c-1:0]  mem_wr_cmd_addr,
  output logic [toe_mem_pkg::mem_len_width_c-1:0]   mem_wr_cmd_len,
  input  logic                                      mem_rd_data_valid,
  output logic                                      mem_rd_data_ready,
  input  logic [DATA_WIDTH-1:0]                     mem_rd_data_data,
  input  logic [KEEP_WIDTH-1:0]                     mem_rd_data_keep,
  input  logic                                      mem_rd_data_last,
  output logic                                      rd_data_valid,
  input  logic                                      rd_data_ready,
  output logic [DATA_WIDTH-1:0]                     rd_data_data,
  output logic [KEEP_WIDTH-1:0]                     rd_data_keep,
  output logic                                      rd_data_last,
  input  logic                                      wr_data_valid,
  output logic                                      wr_data_ready,
  input  logic [DATA_WIDTH-1:0]                     wr_data_data,
  input  logic [KEEP_WIDTH-1:0]                     wr_data_keep,
  input  logic                                      wr_data_last,
  output logic                                      mem_wr_data_valid,
  input  logic                                      mem_wr_data_ready,
  output logic [DATA_WIDTH-1:0]                     mem_wr_data_data,
  output logic [KEEP_WIDTH-1:0]                     mem_wr_data_keep,
  output logic                                      mem_wr_data_last
);

  localparam int ADDR_W = toe_mem_pkg::mem_addr_width_c;
  localparam int LEN_W  = toe_mem_pkg::mem_len_width_c;

  // commands, upper address half and upper length bits are always zero
  assign mem_rd_cmd_valid = rd_cmd_valid;
  assign rd_cmd_ready     = mem_rd_cmd_ready;
  assign mem_rd_cmd_addr  = ADDR_W'(rd_cmd_word.fields.addr);
  assign mem_rd_cmd_len   = LEN_W'(rd_cmd_word.fields.len);

  assign mem_wr_cmd_valid = wr_cmd_valid;
  assign wr_cmd_ready     = mem_wr_cmd_ready;
  assign mem_wr_cmd_addr  = ADDR_W'(wr_cmd_word.fields.addr);
  assign mem_wr_cmd_len   = LEN_W'(wr_cmd_word.fields.len);

  // memory -> engine
  assign rd_data_valid     = mem_rd_data_valid;
  assign mem_rd_data_ready = rd_data_ready;
  assign rd_data_data      = mem_rd_data_data;
  assign rd_data_keep      = mem_rd_data_keep;
  assign rd_data_last      = mem_rd_data_last;

  // engine -> memory
  assign mem_wr_data_valid = wr_data_valid;
  assign wr_data_ready     = mem_wr_data_ready;
  assign mem_wr_data_data  = wr_data_data;
  assign mem_wr_data_keep  = wr_data_keep;
  assign mem_wr_data_last  = wr_data_last;

  // engine leaves reserved and pad bits clear, else the unpacked command is wrong
  a_rd_cmd_clean : assert property (@(posedge net_clk) disable iff (!net_aresetn)
    rd_cmd_valid && rd_cmd_ready |-> rd_cmd_word.fields.reserved == '0
                                     && rd_cmd_word.fields.pad == '0);

  a_wr_cmd_clean : assert property (@(posedge net_clk) disable iff (!net_aresetn)
    wr_cmd_valid && wr_cmd_ready |-> wr_cmd_word.fields.reserved == '0
                                     && wr_cmd_word.fields.pad == '0);

endmodule

/* hdl/tx_read_stats.sv */
module tx_read_stats (
  input  logic                                        net_clk,
  input  logic                                        net_aresetn,
  input  logic                                        rd_cmd_valid,
  input  logic                                        rd_cmd_ready,
  input  logic                                        rd_data_valid,
  input  logic                                        rd_data_ready,
  input  logic                                        rd_data_last,
  output logic [toe_mem_pkg::stat_count_width_c-1:0]  rd_cmd_count,
  output logic [toe_mem_pkg::stat_count_width_c-1:0]  rd_pkg_count
);

  logic cmd_fire;
  logic pkg_fire;

  assign cmd_fire = rd_cmd_valid && rd_cmd_ready;
  assign pkg_fire = rd_data_valid && rd_data_ready && rd_data_last; // end of package

  always_ff @(posedge net_clk) begin
    if (!net_aresetn) begin
      rd_cmd_count <= '0;
      rd_pkg_count <= '0;
    end else begin
      if (cmd_fire) begin
        rd_cmd_count <= rd_cmd_count + 1'b1; // wraps
      end
      if (pkg_fire) begin
        rd_pkg_count <= rd_pkg_count + 1'b1;
      end
    end
  end

endmodule

/* hdl/toe_buffer_shell.sv */
module toe_buffer_shell #(
  parameter int DATA_WIDTH      = toe_stream_pkg::data_width_c,
  parameter int KEEP_WIDTH      = toe_stream_pkg::keep_width_c,
  parameter int RX_BUFFER_DEPTH = toe_stream_pkg::rx_buffer_depth_c
) (
  input  logic                                             net_clk,
  input  logic                                             net_aresetn,
  // receive payload, engine to application
  input  logic                                             eng_rx_valid,
  output logic                                             eng_rx_ready,
  input  logic [DATA_WIDTH-1:0]                            eng_rx_data,
  input  logic [KEEP_WIDTH-1:0]                            eng_rx_keep,
  input  logic                                             eng_rx_last,
  output logic                                             app_rx_valid,
  input  logic                                             app_rx_ready,
  output logic [DATA_WIDTH-1:0]                            app_rx_data,
  output logic [KEEP_WIDTH-1:0]                            app_rx_keep,
  output logic                                             app_rx_last,
  output logic [toe_stream_pkg::fill_count_width_c-1:0]    rx_fill_count,
  // metadata
  input  logic                                             app_listen_valid,
  output logic                                             app_listen_ready,
  input  logic [toe_stream_pkg::listen_port_width_c-1:0]   app_listen_data,
  output logic                                             eng_listen_valid,
  input  logic                                             eng_listen_ready,
  output logic [toe_stream_pkg::listen_port_width_c-1:0]   eng_listen_data,
  input  logic                                             eng_notif_valid,
  output logic                                             eng_notif_ready,
  input  logic [toe_stream_pkg::notification_width_c-1:0]  eng_notif_data,
  output logic                                             app_notif_valid,
  input  logic                                             app_notif_ready,
  output logic [toe_stream_pkg::notification_width_c-1:0]  app_notif_data,
  // transmit memory commands
  input  logic                                             eng_rd_cmd_valid,
  output logic                                             eng_rd_cmd_ready,
  input  logic [toe_mem_pkg::mem_cmd_word_width_c-1:0]     eng_rd_cmd_word,
  output logic                                             mem_rd_cmd_valid,
  input  logic                                             mem_rd_cmd_ready,
  output logic [toe_mem_pkg::mem_addr_width_c-1:0]         mem_rd_cmd_addr,
  output logic [toe_mem_pkg::mem_len_width_c-1:0]          mem_rd_cmd_len,
  input  logic                                             eng_wr_cmd_valid,
  output logic                                             eng_wr_cmd_ready,
  input  logic [toe_mem_pkg::mem_cmd_word_width_c-1:0]     eng_wr_cmd_word,
  output logic                                             mem_wr_cmd_valid,
  input  logic                                             mem_wr_cmd_ready,
  output logic [toe_mem_pkg::mem_addr_width_c-1:0]         mem_wr_cmd_addr,
  output logic [toe_mem_pkg::mem_len_width_c-1:0]          mem_wr_cmd_len,
  // transmit memory data
  input  logic                                             mem_rd_data_valid,
  output logic                                             mem_rd_data_ready,
  input  logic [DATA_WIDTH-1:0]                            mem_rd_data_data,
  input  logic [KEEP_WIDTH-1:0]                            mem_rd_data_keep,
  input  logic                                             mem_rd_data_last,
  output logic                                             eng_rd_data_valid,
  input  logic                                             eng_rd_data_ready,
  output logic [DATA_WIDTH-1:0]                            eng_rd_data_data,
  output logic [KEEP_WIDTH-1:0]                            eng_rd_data_keep,
  output logic                                             eng_rd_data_last,
  input  logic                                             eng_wr_data_valid,
  output logic                                             eng_wr_data_ready,
  input  logic [DATA_WIDTH-1:0]                            eng_wr_data_data,
  input  logic [KEEP_WIDTH-1:0]                            eng_wr_data_keep,
  input  logic                                             eng_wr_data_last,
  output logic                                             mem_wr_data_valid,
  input  logic                                             mem_wr_data_ready,
  output logic [DATA_WIDTH-1:0]                            mem_wr_data_data,
  output logic [KEEP_WIDTH-1:0]                            mem_wr_data_keep,
  output logic                                             mem_wr_data_last,
  // read traffic status
  output logic [toe_mem_pkg::stat_count_width_c-1:0]       rd_cmd_count,
  output logic [toe_mem_pkg::stat_count_width_c-1:0]       rd_pkg_count
);

  rx_buffer_fifo #(
    .DATA_WIDTH      (DATA_WIDTH),
    .KEEP_WIDTH      (KEEP_WIDTH),
    .RX_BUFFER_DEPTH (RX_BUFFER_DEPTH)
  ) i_rx_buffer (
    .net_clk, .net_aresetn,
    .in_valid   (eng_rx_valid),
    .in_ready   (eng_rx_ready),
    .in_data    (eng_rx_data),
    .in_keep    (eng_rx_keep),
    .in_last    (eng_rx_last),
    .out_valid  (app_rx_valid),
    .out_ready  (app_rx_ready),
    .out_data   (app_rx_data),
    .out_keep   (app_rx_keep),
    .out_last   (app_rx_last),
    .fill_count (rx_fill_count)
  );

  meta_reg_slice #(.WIDTH(toe_stream_pkg::listen_port_width_c)) i_listen_slice (
    .net_clk, .net_aresetn,
    .in_valid  (app_listen_valid),
    .in_ready  (app_listen_ready),
    .in_data   (app_listen_data),
    .out_valid (eng_listen_valid),
    .out_ready (eng_listen_ready),
    .out_data  (eng_listen_data)
  );

  meta_reg_slice #(.WIDTH(toe_stream_pkg::notification_width_c)) i_notif_slice (
    .net_clk, .net_aresetn,
    .in_valid  (eng_notif_valid),
    .in_ready  (eng_notif_ready),
    .in_data   (eng_notif_data),
    .out_valid (app_notif_valid),
    .out_ready (app_notif_ready),
    .out_data  (app_notif_data)
  );

  tx_mem_port #(
    .DATA_WIDTH (DATA_WIDTH),
    .KEEP_WIDTH (KEEP_WIDTH)
  ) i_tx_mem_port (
    .net_clk, .net_aresetn,
    .rd_cmd_valid (eng_rd_cmd_valid),
    .rd_cmd_ready (eng_rd_cmd_ready),
    .rd_cmd_word  (eng_rd_cmd_word),
    .mem_rd_cmd_valid, .mem_rd_cmd_ready, .mem_rd_cmd_addr, .mem_rd_cmd_len,
    .wr_cmd_valid (eng_wr_cmd_valid),
    .wr_cmd_ready (eng_wr_cmd_ready),
    .wr_cmd_word  (eng_wr_cmd_word),
    .mem_wr_cmd_valid, .mem_wr_cmd_ready, .mem_wr_cmd_addr, .mem_wr_cmd_len,
    .mem_rd_data_valid, .mem_rd_data_ready, .mem_rd_data_data,
    .mem_rd_data_keep, .mem_rd_data_last,
    .rd_data_valid (eng_rd_data_valid),
    .rd_data_ready (eng_rd_data_ready),
    .rd_data_data  (eng_rd_data_data),
    .rd_data_keep  (eng_rd_data_keep),
    .rd_data_last  (eng_rd_data_last),
    .wr_data_valid (eng_wr_data_valid),
    .wr_data_ready (eng_wr_data_ready),
    .wr_data_data  (eng_wr_data_data),
    .wr_data_keep  (eng_wr_data_keep),
    .wr_data_last  (eng_wr_data_last),
    .mem_wr_data_valid, .mem_wr_data_ready, .mem_wr_data_data,
    .mem_wr_data_keep, .mem_wr_data_last
  );

  // observes the memory side of the read channel
  tx_read_stats i_rd_stats (
    .net_clk, .net_aresetn,
    .rd_cmd_valid  (mem_rd_cmd_valid),
    .rd_cmd_ready  (mem_rd_cmd_ready),
    .rd_data_valid (mem_rd_data_valid),
    .rd_data_ready (mem_rd_data_ready),
    .rd_data_last  (mem_rd_data_last),
    .rd_cmd_count,
    .rd_pkg_count
  );

endmodule

/* verif/toe_buffer_shell_tb.sv */
module toe_buffer_shell_tb;

  localparam int rows_c    = 8;
  localparam int depth_c   = 16; // small enough to reach full
  localparam int timeout_c = 20 * rows_c + 200;
  localparam int dw_c      = toe_stream_pkg::data_width_c;
  localparam int kw_c      = toe_stream_pkg::keep_width_c;
  localparam int lw_c      = toe_stream_pkg::listen_port_width_c;
  localparam int nw_c      = toe_stream_pkg::notification_width_c;
  localparam int cw_c      = toe_mem_pkg::mem_cmd_word_width_c;
  localparam int aw_c      = toe_mem_pkg::mem_addr_width_c;
  localparam int ln_c      = toe_mem_pkg::mem_len_width_c;
  localparam int sw_c      = toe_mem_pkg::stat_count_width_c;

  typedef struct packed {
    logic [cw_c-1:0] cmd_word;
    logic [aw_c-1:0] addr; // word bits 63:32, zero extended
    logic [ln_c-1:0] len;  // word bits 22:0, zero extended
    logic [dw_c-1:0] data;
    logic [kw_c-1:0] keep;
    logic            last;
    logic [lw_c-1:0] listen;
  } stim_row_t;

  stim_row_t table_rows [rows_c] = '{
    '{72'h00_0000_1000_0000_0040, 64'h1000, 32'h40, 64'h0123456789abcdef, 8'hff, 1'b0, 16'd80},
    '{72'h00_ffff_fffc_007f_ffff, 64'hffff_fffc, 32'h7f_ffff, 64'hfedcba9876543210, 8'h0f,
      1'b1, 16'd443},
    '{72'h00_8000_0000_0000_0001, 64'h8000_0000, 32'h1, 64'h0, 8'hff, 1'b0, 16'd0},
    '{72'h00_dead_beef_0012_3456, 64'hdead_beef, 32'h12_3456, 64'hffffffffffffffff, 8'h01,
      1'b1, 16'd65535},
    '{72'h00_0000_0000_0000_0000, 64'h0, 32'h0, 64'h5a5a5a5a5a5a5a5a, 8'h3f, 1'b1, 16'd8080},
    '{72'h00_0001_0000_0040_0000, 64'h1_0000, 32'h40_0000, 64'ha5a5a5a5a5a5a5a5, 8'hff,
      1'b0, 16'd22},
    '{72'h00_1234_5678_0000_05dc, 64'h1234_5678, 32'h5dc, 64'h0000000100000002, 8'hff,
      1'b0, 16'd1},
    '{72'h00_a5a5_5a5a_0055_aa55, 64'ha5a5_5a5a, 32'h55_aa55, 64'h8000000000000001, 8'h80,
      1'b1, 16'd5001}
  };

  logic net_clk;
  logic net_aresetn;
  logic eng_rx_valid, eng_rx_ready, eng_rx_last;
  logic app_rx_valid, app_rx_ready, app_rx_last;
  logic [dw_c-1:0] eng_rx_data, app_rx_data;
  logic [kw_c-1:0] eng_rx_keep, app_rx_keep;
  logic [toe_stream_pkg::fill_count_width_c-1:0] rx_fill_count;
  logic app_listen_valid, app_listen_ready, eng_listen_valid, eng_listen_ready;
  logic [lw_c-1:0] app_listen_data, eng_listen_data;
  logic eng_notif_valid, eng_notif_ready, app_notif_valid, app_notif_ready;
  logic [nw_c-1:0] eng_notif_data, app_notif_data;
  logic eng_rd_cmd_valid, eng_rd_cmd_ready, mem_rd_cmd_valid, mem_rd_cmd_ready;
  logic eng_wr_cmd_valid, eng_wr_cmd_ready, mem_wr_cmd_valid, mem_wr_cmd_ready;
  logic [cw_c-1:0] eng_rd_cmd_word, eng_wr_cmd_word;
  logic [aw_c-1:0] mem_rd_cmd_addr, mem_wr_cmd_addr;
  logic [ln_c-1:0] mem_rd_cmd_len, mem_wr_cmd_len;
  logic mem_rd_data_valid, mem_rd_data_ready, mem_rd_data_last;
  logic eng_rd_data_valid, eng_rd_data_ready, eng_rd_data_last;
  logic [dw_c-1:0] mem_rd_data_data, eng_rd_data_data;
  logic [kw_c-1:0] mem_rd_data_keep, eng_rd_data_keep;
  logic eng_wr_data_valid, eng_wr_data_ready, eng_wr_data_last;
  logic mem_wr_data_valid, mem_wr_data_ready, mem_wr_data_last;
  logic [dw_c-1:0] eng_wr_data_data, mem_wr_data_data;
  logic [kw_c-1:0] eng_wr_data_keep, mem_wr_data_keep;
  logic [sw_c-1:0] rd_cmd_count, rd_pkg_count;

  logic [sw_c-1:0] exp_cmd_count = '0; // counted from the stimulus side
  logic [sw_c-1:0] exp_pkg_count = '0;
  int              cycle_count = 0;

  toe_buffer_shell #(.RX_BUFFER_DEPTH(depth_c)) i_dut (.*);

  initial begin
    net_clk = 1'b0;
    forever #20 net_clk = ~net_clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      abort_run($sformatf("FAILED at %0t: %s expected %0h, got %0h",
                          $time, name, expected, actual));
    end
  endtask

  function automatic logic random_bit();
    return 1'($urandom_range(0, 1));
  endfunction

  // ends a run that stalls on a lost handshake
  always @(posedge net_clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_c) begin
      abort_run($sformatf("timeout, tests still running after %0d cycles", cycle_count));
    end
  end

  // reference counts from the driven read handshakes
  always @(negedge net_clk) begin
    if (net_aresetn) begin
      if (eng_rd_cmd_valid && mem_rd_cmd_ready) begin
        exp_cmd_count <= exp_cmd_count + 1'b1;
      end
      if (mem_rd_data_valid && eng_rd_data_ready && mem_rd_data_last) begin
        exp_pkg_count <= exp_pkg_count + 1'b1;
      end
    end
  end

  task automatic check_reset_state();
    @(negedge net_clk);
    check_value("app_rx_valid", 0, app_rx_valid);
    check_value("eng_listen_valid", 0, eng_listen_valid);
    check_value("app_notif_valid", 0, app_notif_valid);
    check_value("rx_fill_count", 0, rx_fill_count);
    check_value("rd_cmd_count", 0, rd_cmd_count);
    check_value("rd_pkg_count", 0, rd_pkg_count);
  endtask

  task automatic check_unpacking();
    int j;
    for (int i = 0; i < rows_c; i++) begin
      j = (i + 3) % rows_c; // write side uses a different row
      @(posedge net_clk);
      eng_rd_cmd_valid <= 1'b1;
      eng_rd_cmd_word <= table_rows[i].cmd_word;
      mem_rd_cmd_ready <= 1'b1;
      eng_wr_cmd_valid <= !i[1];
      eng_wr_cmd_word <= table_rows[j].cmd_word;
      mem_wr_cmd_ready <= !i[0];
      eng_wr_data_valid <= i[1];
      eng_wr_data_data <= table_rows[i].data;
      eng_wr_data_keep <= table_rows[i].keep;
      eng_wr_data_last <= table_rows[i].last;
      mem_wr_data_ready <= i[0];
      @(negedge net_clk);
      check_value("mem_rd_cmd_valid", 1, mem_rd_cmd_valid);
      check_value("eng_rd_cmd_ready", 1, eng_rd_cmd_ready);
      check_value("mem_rd_cmd_addr", table_rows[i].addr, mem_rd_cmd_addr);
      check_value("mem_rd_cmd_len", table_rows[i].len, mem_rd_cmd_len);
      check_value("mem_wr_cmd_valid", !i[1], mem_wr_cmd_valid);
      check_value("eng_wr_cmd_ready", !i[0], eng_wr_cmd_ready);
      check_value("mem_wr_cmd_addr", table_rows[j].addr, mem_wr_cmd_addr);
      check_value("mem_wr_cmd_len", table_rows[j].len, mem_wr_cmd_len);
      check_value("mem_wr_data_valid", i[1], mem_wr_data_valid);
      check_value("mem_wr_data_data", table_rows[i].data, mem_wr_data_data);
      check_value("mem_wr_data_keep", table_rows[i].keep, mem_wr_data_keep);
      check_value("mem_wr_data_last", table_rows[i].last, mem_wr_data_last);
      check_value("eng_wr_data_ready", i[0], eng_wr_data_ready);
    end
    @(posedge net_clk);
    eng_rd_cmd_valid <= 1'b0;
    eng_wr_cmd_valid <= 1'b0;
    mem_rd_cmd_ready <= 1'b0;
    mem_wr_cmd_ready <= 1'b0;
    eng_wr_data_valid <= 1'b0;
  endtask

  task automatic send_rx_rows();
    int gap;
    for (int i = 0; i < rows_c; i++) begin
      gap = $urandom_range(0, 2);
      repeat (gap) begin
        @(posedge net_clk);
        eng_rx_valid <= 1'b0;
      end
      @(posedge net_clk);
      eng_rx_valid <= 1'b1;
      eng_rx_data <= table_rows[i].data;
      eng_rx_keep <= table_rows[i].keep;
      eng_rx_last <= table_rows[i].last;
      do begin
        @(negedge net_clk);
      end while (!eng_rx_ready); // held until the FIFO takes it
    end
    @(posedge net_clk);
    eng_rx_valid <= 1'b0;
  endtask

  task automatic take_rx_rows();
    bit got;
    for (int i = 0; i < rows_c; i++) begin
      got = 1'b0;
      while (!got) begin
        @(posedge net_clk);
        app_rx_ready <= random_bit();
        @(negedge net_clk);
        if (app_rx_valid && app_rx_ready) begin
          check_value("app_rx_data", table_rows[i].data, app_rx_data);
          check_value("app_rx_keep", table_rows[i].keep, app_rx_keep);
          check_value("app_rx_last", table_rows[i].last, app_rx_last);
          got = 1'b1;
        end
      end
    end
    @(posedge net_clk);
    app_rx_ready <= 1'b0;
  endtask

  task automatic fill_and_drain();
    int accepted;
    int drained;
    bit full_seen;
    accepted = 0;
    drained = 0;
    full_seen = 1'b0;
    while (!full_seen) begin
      @(posedge net_clk);
      eng_rx_valid <= 1'b1;
      eng_rx_data <= table_rows[accepted % rows_c].data;
      eng_rx_keep <= table_rows[accepted % rows_c].keep;
      eng_rx_last <= table_rows[accepted % rows_c].last;
      @(negedge net_clk);
      if (eng_rx_ready) begin
        accepted++;
      end else begin
        full_seen = 1'b1;
      end
    end
    @(posedge net_clk);
    eng_rx_valid <= 1'b0;
    check_value("accepted beats", depth_c, accepted);
    repeat (3) @(posedge net_clk); // count runs through two stages
    @(negedge net_clk);
    check_value("rx_fill_count", depth_c, rx_fill_count);
    @(posedge net_clk);
    app_rx_ready <= 1'b1;
    while (drained < accepted) begin
      @(negedge net_clk);
      if (app_rx_valid) begin
        check_value("app_rx_data", table_rows[drained % rows_c].data, app_rx_data);
        drained++;
      end
    end
    @(posedge net_clk);
    app_rx_ready <= 1'b0;
    repeat (3) @(posedge net_clk);
    @(negedge net_clk);
    check_value("app_rx_valid", 0, app_rx_valid);
    check_value("rx_fill_count", 0, rx_fill_count);
  endtask

  task automatic pass_metadata();
    int send_l;
    int recv_l;
    int send_n;
    int recv_n;
    send_l = 0;
    recv_l = 0;
    send_n = 0;
    recv_n = 0;
    while (recv_l < rows_c || recv_n < rows_c) begin
      @(posedge net_clk);
      app_listen_valid <= (send_l < rows_c);
      app_listen_data <= table_rows[send_l % rows_c].listen;
      eng_notif_valid <= (send_n < rows_c);
      eng_notif_data <= {table_rows[send_n % rows_c].cmd_word, table_rows[send_n % rows_c].listen};
      eng_listen_ready <= random_bit();
      app_notif_ready <= random_bit();
      @(negedge net_clk);
      if (app_listen_valid && app_listen_ready) send_l++;
      if (eng_notif_valid && eng_notif_ready) send_n++;
      if (eng_listen_valid && eng_listen_ready) begin
        if (recv_l >= rows_c) begin
          abort_run("listen slice delivered more words than were sent");
        end else begin
          check_value("eng_listen_data", table_rows[recv_l].listen, eng_listen_data);
          recv_l++;
        end
      end
      if (app_notif_valid && app_notif_ready) begin
        if (recv_n >= rows_c) begin
          abort_run("notification slice delivered more words than were sent");
        end else begin
          check_value("app_notif_data",
                      {table_rows[recv_n].cmd_word, table_rows[recv_n].listen}, app_notif_data);
          recv_n++;
        end
      end
    end
    @(posedge net_clk);
    app_listen_valid <= 1'b0;
    eng_notif_valid <= 1'b0;
    eng_listen_ready <= 1'b1;
    app_notif_ready <= 1'b1;
    repeat (2) @(posedge net_clk);
    @(negedge net_clk);
    check_value("eng_listen_valid", 0, eng_listen_valid); // nothing duplicated
    check_value("app_notif_valid", 0, app_notif_valid);
  endtask

  task automatic count_reads();
    int cmd_i;
    int data_i;
    cmd_i = 0;
    data_i = 0;
    while (cmd_i < rows_c || data_i < rows_c) begin
      @(posedge net_clk);
      eng_rd_cmd_valid <= (cmd_i < rows_c);
      eng_rd_cmd_word <= table_rows[cmd_i % rows_c].cmd_word;
      mem_rd_cmd_ready <= random_bit();
      mem_rd_data_valid <= (data_i < rows_c);
      mem_rd_data_data <= table_rows[data_i % rows_c].data;
      mem_rd_data_keep <= table_rows[data_i % rows_c].keep;
      mem_rd_data_last <= table_rows[data_i % rows_c].last;
      eng_rd_data_ready <= random_bit();
      @(negedge net_clk);
      check_value("mem_rd_cmd_valid", eng_rd_cmd_valid, mem_rd_cmd_valid);
      check_value("eng_rd_cmd_ready", mem_rd_cmd_ready, eng_rd_cmd_ready);
      check_value("eng_rd_data_valid", mem_rd_data_valid, eng_rd_data_valid);
      check_value("mem_rd_data_ready", eng_rd_data_ready, mem_rd_data_ready);
      if (eng_rd_cmd_valid && mem_rd_cmd_ready) cmd_i++;
      if (mem_rd_data_valid && eng_rd_data_ready) begin
        check_value("eng_rd_data_data", table_rows[data_i].data, eng_rd_data_data);
        check_value("eng_rd_data_keep", table_rows[data_i].keep, eng_rd_data_keep);
        check_value("eng_rd_data_last", table_rows[data_i].last, eng_rd_data_last);
        data_i++;
      end
    end
    @(posedge net_clk);
    eng_rd_cmd_valid <= 1'b0;
    mem_rd_data_valid <= 1'b0;
    mem_rd_cmd_ready <= 1'b0;
    eng_rd_data_ready <= 1'b0;
    @(posedge net_clk);
    @(negedge net_clk);
    check_value("rd_cmd_count", exp_cmd_count, rd_cmd_count);
    check_value("rd_pkg_count", exp_pkg_count, rd_pkg_count);
  endtask

  initial begin
    void'($urandom(44017));
    net_aresetn <= 1'b0;
    eng_rx_valid <= 1'b0;
    eng_rx_data <= '0;
    eng_rx_keep <= '0;
    eng_rx_last <= 1'b0;
    app_rx_ready <= 1'b0;
    app_listen_valid <= 1'b0;
    app_listen_data <= '0;
    eng_listen_ready <= 1'b0;
    eng_notif_valid <= 1'b0;
    eng_notif_data <= '0;
    app_notif_ready <= 1'b0;
    eng_rd_cmd_valid <= 1'b0;
    eng_rd_cmd_word <= '0;
    mem_rd_cmd_ready <= 1'b0;
    eng_wr_cmd_valid <= 1'b0;
    eng_wr_cmd_word <= '0;
    mem_wr_cmd_ready <= 1'b0;
    mem_rd_data_valid <= 1'b0;
    mem_rd_data_data <= '0;
    mem_rd_data_keep <= '0;
    mem_rd_data_last <= 1'b0;
    eng_rd_data_ready <= 1'b0;
    eng_wr_data_valid <= 1'b0;
    eng_wr_data_data <= '0;
    eng_wr_data_keep <= '0;
    eng_wr_data_last <= 1'b0;
    mem_wr_data_ready <= 1'b0;
    repeat (2) @(posedge net_clk);
    net_aresetn <= 1'b1;
    check_reset_state();
    check_unpacking();
    fork
      send_rx_rows();
      take_rx_rows();
    join
    fill_and_drain();
    pass_metadata();
    count_reads();
    $display("All tests passed");
    $finish;
  end

endmodule

/* toe_buffer_shell.f */
hdl/toe_stream_pkg.sv
hdl/toe_mem_pkg.sv
hdl/meta_reg_slice.sv
hdl/rx_buffer_fifo.sv
hdl/tx_mem_port.sv
hdl/tx_read_stats.sv
hdl/toe_buffer_shell.sv
verif/toe_buffer_shell_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= toe_buffer_shell_tb
FILELIST  ?= toe_buffer_shell.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
